// File: video_defines.svh
/*
 * Video subsystem constants
 *   Screen geometry and sync positions
 *   CPU address map and sprite half of the graphics ROM
 */
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Geometry in pixels and lines
`define H_TOTAL     96
`define H_ACTIVE    64
`define V_TOTAL     40
`define V_ACTIVE    32

`define HS_START    72
`define HS_END      80
`define VS_LINE     35

// CPU address map
`define MAP_BASE    12'h000   // 128 bytes, 16 x 8 tile codes
`define SCROLL_ADDR 12'h080
`define OBJ_BASE    12'h100   // 4 sprites of 4 bytes
`define PAL_BASE    12'h200   // 64 words, high byte first

`define OBJ_ROM_BIT 11

`endif

// File: video_pkg.sv
/*
 * Pixel and palette types
 *   Tile colour nibble
 *   Sprite pixel with priority and bank
 *   Palette word with colour and byte views
 */
package video_pkg;

    // Colour nibble, zero is transparent
    typedef logic [3:0] pxl_idx_t;

    typedef struct packed {
        logic     behind;   // Hidden by opaque tile pixels
        logic     bank;
        pxl_idx_t nibble;
    } obj_pxl_t;

    typedef struct packed {
        logic       spare;
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
    } pal_col_t;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } pal_bytes_t;

    // Same palette word, seen by the mixer or by the CPU
    typedef union packed {
        pal_col_t   col;
        pal_bytes_t bytes;
    } pal_word_u;

endpackage

// File: bus_pkg.sv
/*
 * Bus request types
 *   CPU byte access with single-cycle strobe
 *   Graphics ROM request held until acknowledged
 */
package bus_pkg;

    typedef struct packed {
        logic        stb;
        logic        we;
        logic [11:0] addr;
        logic [7:0]  wdata;
    } cpu_req_t;

    // Held stable until rom_ok
    typedef struct packed {
        logic        cs;
        logic [11:0] addr;   // 32-bit word address
    } rom_req_t;

endpackage

// File: video_timing.sv
/*
 * Video timing generator
 *   Pixel and line counters stepped by the pixel clock enable
 *   Registered blanking and sync levels
 */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_timing (
    input  logic       clk,
    input  logic       reset,
    input  logic       pxl_cen,
    output logic [6:0] hdump,
    output logic [5:0] vdump,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs
);

    logic [6:0] h_next;
    logic [5:0] v_next;

    always_comb begin
        h_next = (hdump == 7'(`H_TOTAL - 1)) ? 7'd0 : hdump + 7'd1;
        v_next = vdump;
        if (h_next == 7'd0)  // New line on pixel wrap
            v_next = (vdump == 6'(`V_TOTAL - 1)) ? 6'd0 : vdump + 6'd1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // End of the visible part of the last line
            hdump <= 7'(`H_ACTIVE - 1);
            vdump <= 6'(`V_TOTAL - 1);
            lhbl  <= 1'b0;
            lvbl  <= 1'b0;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= h_next;
            vdump <= v_next;
            lhbl  <= h_next < 7'(`H_ACTIVE);
            lvbl  <= v_next < 6'(`V_ACTIVE);
            hs    <= h_next >= 7'(`HS_START) && h_next < 7'(`HS_END);
            vs    <= v_next == 6'(`VS_LINE);
        end
    end

endmodule

// File: tile_layer.sv
/*
 * Scrolling tile layer
 *   Tile map RAM and horizontal scroll register
 *   Row word fetch one tile ahead into a holding register
 *   Nibble shifter giving the pixel at the current hdump
 */
`timescale 1ns/1ps
`include "video_defines.svh"

module tile_layer (
    input  logic                clk,
    input  logic                reset,
    input  logic                pxl_cen,
    input  bus_pkg::cpu_req_t   cpu,
    input  logic [6:0]          hdump,
    input  logic [5:0]          vdump,
    input  logic                lhbl,
    output bus_pkg::rom_req_t   rom_req,
    input  logic [31:0]         rom_data,
    input  logic                rom_ok,
    output video_pkg::pxl_idx_t pxl
);

    localparam int HB_FETCH = `H_ACTIVE + 8;   // First tile of next line
    localparam int HB_LOAD  = `H_ACTIVE + 20;  // Shifter preload

    logic [7:0]  map_ram [128];
    logic [7:0]  scroll_x;
    logic [31:0] hold, shifter;
    logic        hold_full, fetch_cs;
    logic [11:0] fetch_addr;
    logic [3:0]  fetch_col, want_col;
    logic [5:0]  line_y, want_y;
    logic [6:0]  h_next;
    logic [7:0]  sx_next, want_code;
    logic        hb_fetch, hb_load, tile_edge, reload;

    always_ff @(posedge clk) begin
        if (cpu.stb && cpu.we && cpu.addr[11:7] == 5'(`MAP_BASE >> 7))
            map_ram[cpu.addr[6:0]] <= cpu.wdata;
    end

    always_ff @(posedge clk) begin
        if (reset)
            scroll_x <= 8'd0;
        else if (cpu.stb && cpu.we && cpu.addr == `SCROLL_ADDR)
            scroll_x <= cpu.wdata;
    end

    always_comb begin
        h_next    = (hdump == 7'(`H_TOTAL - 1)) ? 7'd0 : hdump + 7'd1;
        sx_next   = {1'b0, h_next} + scroll_x;
        hb_fetch  = pxl_cen && h_next == 7'(HB_FETCH);
        hb_load   = pxl_cen && h_next == 7'(HB_LOAD);
        // Tile boundary inside the visible part
        // Pixel 0 comes from the preload instead
        tile_edge = pxl_cen && h_next != 7'd0 && h_next < 7'(`H_ACTIVE)
                    && sx_next[2:0] == 3'd0;
        reload    = hb_load || tile_edge;
        if (hb_fetch) begin
            want_y   = (vdump == 6'(`V_TOTAL - 1)) ? 6'd0 : vdump + 6'd1;
            want_col = scroll_x[6:3];
        end else begin
            want_y   = line_y;
            want_col = fetch_col + 4'd1;  // Wraps at column 16
        end
        want_code = map_ram[{want_y[5:3], want_col}];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_cs  <= 1'b0;
            hold_full <= 1'b0;
        end else begin
            if (fetch_cs && rom_ok) begin
                fetch_cs  <= 1'b0;
                hold_full <= 1'b1;
            end
            if (hb_fetch || reload) begin
                fetch_cs  <= 1'b1;
                hold_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_cs && rom_ok)
            hold <= rom_data;
        if (hb_fetch || reload) begin
            fetch_addr <= {1'b0, want_code, want_y[2:0]};
            fetch_col  <= want_col;
            line_y     <= want_y;
        end
        if (hb_load)
            shifter <= hold << {scroll_x[2:0], 2'b00};  // Fine scroll
        else if (tile_edge)
            shifter <= hold;
        else if (pxl_cen && lhbl)
            shifter <= shifter << 4;  // Preload waits through the blank
    end

    assign rom_req = '{cs: fetch_cs, addr: fetch_addr};
    assign pxl     = lhbl ? shifter[31:28] : 4'd0;

    // Row word must land before the tile boundary that consumes it
    assert property (@(posedge clk) disable iff (reset) reload |-> hold_full);

endmodule

// File: obj_layer.sv
/*
 * Sprite layer
 *   Sprite table RAM written by the CPU
 *   Per-line search and ROM fetch during horizontal blank
 *   Line buffer read at hdump and cleared behind the read
 */
`timescale 1ns/1ps
`include "video_defines.svh"

module obj_layer (
    input  logic                clk,
    input  logic                reset,
    input  logic                pxl_cen,
    input  bus_pkg::cpu_req_t   cpu,
    input  logic [6:0]          hdump,
    input  logic [5:0]          vdump,
    input  logic                lhbl,
    output bus_pkg::rom_req_t   rom_req,
    input  logic [31:0]         rom_data,
    input  logic                rom_ok,
    output video_pkg::obj_pxl_t pxl
);

    typedef enum logic [1:0] {S_IDLE, S_CHECK, S_FETCH, S_DRAW} state_t;

    logic [7:0]          obj_ram [16];
    video_pkg::obj_pxl_t line_buf [64];
    logic [63:0]         line_valid;
    state_t              state;
    logic [1:0]          spr;
    logic [2:0]          col;
    logic [5:0]          scan_line;
    logic [8:0]          draw_x;
    logic [31:0]         draw_word;
    logic                fetch_cs;
    logic [11:0]         fetch_addr;
    logic [7:0]          spr_y, spr_x, spr_code, spr_attr, dy;
    logic                draw_we;
    video_pkg::obj_pxl_t draw_pxl;

    always_ff @(posedge clk) begin
        if (cpu.stb && cpu.we && cpu.addr[11:4] == 8'(`OBJ_BASE >> 4))
            obj_ram[cpu.addr[3:0]] <= cpu.wdata;
    end

    always_comb begin
        spr_y    = obj_ram[{spr, 2'd0}];
        spr_x    = obj_ram[{spr, 2'd1}];
        spr_code = obj_ram[{spr, 2'd2}];
        spr_attr = obj_ram[{spr, 2'd3}];
        dy       = {2'b00, scan_line} - spr_y;
        draw_pxl = '{behind: spr_attr[7], bank: spr_attr[0], nibble: draw_word[31:28]};
        // Clip at the right edge, keep what a lower sprite already wrote
        draw_we  = state == S_DRAW && draw_x < 9'd64 && draw_pxl.nibble != 4'd0
                   && !line_valid[draw_x[5:0]];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            fetch_cs <= 1'b0;
            spr      <= 2'd0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (pxl_cen && hdump == 7'(`H_ACTIVE - 1)) begin
                        scan_line <= (vdump == 6'(`V_TOTAL - 1)) ? 6'd0 : vdump + 6'd1;
                        spr       <= 2'd0;
                        state     <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (dy < 8'd8) begin  // Sprite covers the next line
                        fetch_cs   <= 1'b1;
                        fetch_addr <= 12'(1 << `OBJ_ROM_BIT) | {1'b0, spr_code, dy[2:0]};
                        draw_x     <= {1'b0, spr_x};
                        state      <= S_FETCH;
                    end else begin
                        spr   <= spr + 2'd1;
                        state <= (spr == 2'd3) ? S_IDLE : S_CHECK;
                    end
                end
                S_FETCH: begin
                    if (rom_ok) begin
                        fetch_cs  <= 1'b0;
                        draw_word <= rom_data;
                        col       <= 3'd0;
                        state     <= S_DRAW;
                    end
                end
                default: begin  // One nibble per clock
                    draw_word <= draw_word << 4;
                    draw_x    <= draw_x + 9'd1;
                    col       <= col + 3'd1;
                    if (col == 3'd7) begin
                        spr   <= spr + 2'd1;
                        state <= (spr == 2'd3) ? S_IDLE : S_CHECK;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (draw_we)
            line_buf[draw_x[5:0]] <= draw_pxl;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= '0;
        end else begin
            if (pxl_cen && lhbl)
                line_valid[hdump[5:0]] <= 1'b0;  // Cleared once shown
            if (draw_we)
                line_valid[draw_x[5:0]] <= 1'b1;
        end
    end

    assign rom_req = '{cs: fetch_cs, addr: fetch_addr};
    assign pxl     = (lhbl && line_valid[hdump[5:0]]) ? line_buf[hdump[5:0]] : '0;

    // Sprite search for the next line done before that line starts
    assert property (@(posedge clk) disable iff (reset)
        (pxl_cen && hdump == 7'(`H_TOTAL - 1)) |-> state == S_IDLE);

endmodule

// File: gfx_rom_arbiter.sv
/*
 * Graphics ROM arbiter
 *   Tile layer first at each idle decision
 *   Grant held until the ROM acknowledges
 */
`timescale 1ns/1ps

module gfx_rom_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::rom_req_t tile_req,
    input  bus_pkg::rom_req_t obj_req,
    input  logic              rom_ok,
    output logic              tile_ok,
    output logic              obj_ok,
    output bus_pkg::rom_req_t rom_req
);

    logic busy, gnt_obj, sel_obj;

    assign sel_obj = busy ? gnt_obj : (!tile_req.cs && obj_req.cs);
    assign rom_req = sel_obj ? obj_req : tile_req;
    assign tile_ok = rom_ok && busy && !gnt_obj;
    assign obj_ok  = rom_ok && busy && gnt_obj;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            gnt_obj <= 1'b0;
        end else if (busy) begin
            if (rom_ok)
                busy <= 1'b0;
        end else if (rom_req.cs) begin
            busy    <= 1'b1;
            gnt_obj <= sel_obj;
        end
    end

    // The ROM acknowledges only a granted request that is still held
    assert property (@(posedge clk) disable iff (reset) rom_ok |-> (busy && rom_req.cs));

    // Requesters keep cs and address until acknowledged
    assert property (@(posedge clk) disable iff (reset)
        (rom_req.cs && !rom_ok) |=> (rom_req.cs && $stable(rom_req.addr)));

endmodule

// File: color_mixer.sv
/*
 * Colour mixer
 *   Tile and sprite priority, palette index
 *   Palette RAM with CPU byte read and write
 *   RGB expansion and matching delay of blank and sync
 */
`timescale 1ns/1ps
`include "video_defines.svh"

module color_mixer (
    input  logic                clk,
    input  logic                reset,
    input  logic                pxl_cen,
    input  bus_pkg::cpu_req_t   cpu,
    output logic [7:0]          cpu_rdata,
    output logic                cpu_rvalid,
    input  video_pkg::pxl_idx_t tile_pxl,
    input  video_pkg::obj_pxl_t obj_pxl,
    input  logic                lhbl_in,
    input  logic                lvbl_in,
    input  logic                hs_in,
    input  logic                vs_in,
    output logic                lhbl,
    output logic                lvbl,
    output logic                hs,
    output logic                vs,
    output logic [7:0]          red,
    output logic [7:0]          green,
    output logic [7:0]          blue
);

    video_pkg::pal_word_u pal_ram [64];
    video_pkg::pal_word_u pal_q;
    logic [5:0]           pal_idx;
    logic [3:0]           sync_d1;  // lhbl, lvbl, hs, vs
    logic                 pal_hit, obj_win, show;

    assign pal_hit = cpu.stb && cpu.addr[11:7] == 5'(`PAL_BASE >> 7);
    assign obj_win = obj_pxl.nibble != 4'd0 && (!obj_pxl.behind || tile_pxl == 4'd0);

    // Even address is the high byte
    always_ff @(posedge clk) begin
        if (pal_hit && cpu.we) begin
            if (cpu.addr[0])
                pal_ram[cpu.addr[6:1]].bytes.lo <= cpu.wdata;
            else
                pal_ram[cpu.addr[6:1]].bytes.hi <= cpu.wdata;
        end
        if (pal_hit && !cpu.we)
            cpu_rdata <= cpu.addr[0] ? pal_ram[cpu.addr[6:1]].bytes.lo
                                     : pal_ram[cpu.addr[6:1]].bytes.hi;
    end

    always_ff @(posedge clk) begin
        if (reset)
            cpu_rvalid <= 1'b0;
        else
            cpu_rvalid <= pal_hit && !cpu.we;
    end

    // Two pixel steps, index then palette word
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_idx <= obj_win ? {1'b1, obj_pxl.bank, obj_pxl.nibble} : {2'b00, tile_pxl};
            pal_q   <= pal_ram[pal_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_d1              <= 4'd0;
            {lhbl, lvbl, hs, vs} <= 4'd0;
        end else if (pxl_cen) begin
            sync_d1              <= {lhbl_in, lvbl_in, hs_in, vs_in};
            {lhbl, lvbl, hs, vs} <= sync_d1;
        end
    end

    assign show  = lhbl && lvbl;  // Black while blanked
    assign red   = show ? {pal_q.col.r, pal_q.col.r[4:2]} : 8'd0;
    assign green = show ? {pal_q.col.g, pal_q.col.g[4:2]} : 8'd0;
    assign blue  = show ? {pal_q.col.b, pal_q.col.b[4:2]} : 8'd0;

endmodule

// File: video_top.sv
/*
 * Video subsystem top level
 *   Timing, tile layer, sprite layer, ROM arbiter and mixer
 *   CPU bus fanned out to every block
 */
`timescale 1ns/1ps

module video_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              pxl_cen,
    input  bus_pkg::cpu_req_t cpu,
    output logic [7:0]        cpu_rdata,
    output logic              cpu_rvalid,
    output bus_pkg::rom_req_t rom_req,
    input  logic [31:0]       rom_data,
    input  logic              rom_ok,
    output logic              lhbl,
    output logic              lvbl,
    output logic              hs,
    output logic              vs,
    output logic [7:0]        red,
    output logic [7:0]        green,
    output logic [7:0]        blue
);

    logic [6:0]          hdump;
    logic [5:0]          vdump;
    logic                tim_lhbl, tim_lvbl, tim_hs, tim_vs;
    bus_pkg::rom_req_t   tile_req, obj_req;
    logic                tile_ok, obj_ok;
    video_pkg::pxl_idx_t tile_pxl;
    video_pkg::obj_pxl_t obj_pxl;

    video_timing i_timing (
        .clk, .reset, .pxl_cen, .hdump, .vdump,
        .lhbl (tim_lhbl), .lvbl (tim_lvbl), .hs (tim_hs), .vs (tim_vs)
    );

    tile_layer i_tile (
        .clk, .reset, .pxl_cen, .cpu, .hdump, .vdump, .lhbl (tim_lhbl),
        .rom_req (tile_req), .rom_data, .rom_ok (tile_ok), .pxl (tile_pxl)
    );

    obj_layer i_obj (
        .clk, .reset, .pxl_cen, .cpu, .hdump, .vdump, .lhbl (tim_lhbl),
        .rom_req (obj_req), .rom_data, .rom_ok (obj_ok), .pxl (obj_pxl)
    );

    gfx_rom_arbiter i_arbiter (
        .clk, .reset, .tile_req, .obj_req, .rom_ok, .tile_ok, .obj_ok, .rom_req
    );

    color_mixer i_mixer (
        .clk, .reset, .pxl_cen, .cpu, .cpu_rdata, .cpu_rvalid, .tile_pxl, .obj_pxl,
        .lhbl_in (tim_lhbl), .lvbl_in (tim_lvbl), .hs_in (tim_hs), .vs_in (tim_vs),
        .lhbl, .lvbl, .hs, .vs, .red, .green, .blue
    );

endmodule

// File: video_tb.sv
/*
 * Testbench for the video subsystem
 *   Clock, reset, pixel clock enable and behavioural graphics ROM
 *   CPU write and read tasks, frame capture and pixel reference
 *   Directed tests for timing, palette, tiles, scroll and sprites
 */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_tb;

    logic              clk, reset, pxl_cen;
    bus_pkg::cpu_req_t cpu;
    logic [7:0]        cpu_rdata, red, green, blue;
    logic              cpu_rvalid, lhbl, lvbl, hs, vs;
    bus_pkg::rom_req_t rom_req;
    logic [31:0]       rom_data;
    logic              rom_ok, rom_busy;
    int                rom_left, seed, errors, test_errors, failed_tests;
    string             test_name;
    logic [7:0]        map_model [128];
    logic [7:0]        spr_model [16];   // y, x, code, attr per sprite
    logic [15:0]       pal_model [64];
    logic [7:0]        scroll_model;
    logic [23:0]       frame [2048];     // Visible pixels row by row

    video_top i_dut (
        .clk, .reset, .pxl_cen, .cpu, .cpu_rdata, .cpu_rvalid, .rom_req, .rom_data,
        .rom_ok, .lhbl, .lvbl, .hs, .vs, .red, .green, .blue
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        int phase;
        pxl_cen = 1'b0;
        phase   = 0;
        forever begin
            @(posedge clk);
            #1;
            pxl_cen = (phase == 3);  // One clock in four
            phase   = (phase + 1) % 4;
        end
    end

    // Nibble n counted from the top is the low address bits plus n
    function automatic logic [31:0] rom_word(logic [11:0] addr);
        logic [31:0] w;
        for (int n = 0; n < 8; n++)
            w[31 - 4 * n -: 4] = 4'(addr[3:0] + 4'(n));
        return w;
    endfunction

    function automatic logic [3:0] nibble_of(logic [31:0] w, int n);
        return w[31 - 4 * n -: 4];
    endfunction

    function automatic logic [7:0] expand(logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    // Graphics ROM that acknowledges a held request after 1 to 4 clocks
    initial begin
        rom_ok   = 1'b0;
        rom_busy = 1'b0;
        rom_data = '0;
        rom_left = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rom_ok) begin
                rom_ok   = 1'b0;
                rom_busy = 1'b0;
            end else if (rom_busy) begin
                rom_left = rom_left - 1;
                if (rom_left == 0) begin
                    rom_data = rom_word(rom_req.addr);
                    rom_ok   = 1'b1;
                end
            end else if (rom_req.cs) begin
                rom_busy = 1'b1;
                rom_left = 1 + ($random(seed) & 3);
            end
        end
    end

    task automatic report_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        test_errors++;
        if (test_errors <= 8)
            $display("** Error: %s: %s expected %0h, actual %0h", test_name, what, exp, act);
    endtask

    task automatic report_failure(input string what);
        test_errors++;
        $display("Failure in %s: %s", test_name, what);
    endtask

    task automatic finish_test();
        errors += test_errors;
        if (test_errors != 0)
            failed_tests++;
        $display("Test %-8s %s with %0d errors", test_name,
                 (test_errors == 0) ? "passed" : "failed", test_errors);
    endtask

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic cpu_write(input logic [11:0] addr, input logic [7:0] data);
        step_clock();
        cpu = '{stb: 1'b1, we: 1'b1, addr: addr, wdata: data};
        step_clock();
        cpu.stb = 1'b0;
    endtask

    task automatic cpu_read(input logic [11:0] addr, output logic [7:0] data);
        int n;
        step_clock();
        cpu = '{stb: 1'b1, we: 1'b0, addr: addr, wdata: 8'h00};
        step_clock();
        cpu.stb = 1'b0;
        n = 0;
        while (!cpu_rvalid && n < 8) begin
            step_clock();
            n++;
        end
        assert (cpu_rvalid) else report_failure("no cpu_rvalid after a palette read");
        assert (n == 0) else report_value("read latency in clocks", 32'd1, 32'(n + 1));
        data = cpu_rdata;
    endtask

    // Outputs settle on a pixel step and are sampled on the falling edge
    task automatic next_pixel();
        int n;
        n = 0;
        @(negedge clk);
        while (!pxl_cen && n < 8) begin
            @(negedge clk);
            n++;
        end
        assert (pxl_cen) else report_failure("pixel clock enable stopped");
    endtask

    task automatic capture_frame();
        int n, idx;
        n = 0;
        next_pixel();
        while (!lvbl && n < 4000) begin
            next_pixel();
            n++;
        end
        while (lvbl && n < 8000) begin  // Rest of the current frame
            next_pixel();
            n++;
        end
        idx = 0;
        while (idx < 2048 && n < 16000) begin
            next_pixel();
            n++;
            if (lhbl && lvbl) begin
                frame[idx] = {red, green, blue};
                idx++;
            end
        end
        assert (idx == 2048) else report_failure("frame capture did not complete");
    endtask

    function automatic logic [23:0] expected_rgb(int x, int y);
        logic [7:0]  sx, dy, sy, spx, code, attr;
        logic [3:0]  tile_nib, nib;
        logic [5:0]  idx;
        logic [15:0] w;
        logic        claimed;
        sx       = 8'(x) + scroll_model;
        code     = map_model[(y / 8) * 16 + int'(sx[6:3])];
        tile_nib = nibble_of(rom_word(12'(code * 8 + y % 8)), int'(sx[2:0]));
        idx      = {2'b00, tile_nib};
        claimed  = 1'b0;
        for (int s = 0; s < 4; s++) begin
            sy   = spr_model[4 * s];
            spx  = spr_model[4 * s + 1];
            code = spr_model[4 * s + 2];
            attr = spr_model[4 * s + 3];
            dy   = 8'(y) - sy;
            if (!claimed && dy < 8'd8 && x >= int'(spx) && x < int'(spx) + 8) begin
                nib = nibble_of(rom_word(12'h800 | 12'(code * 8 + dy)), x - int'(spx));
                if (nib != 4'd0) begin
                    claimed = 1'b1;  // First opaque sprite owns the pixel
                    if (!attr[7] || tile_nib == 4'd0)
                        idx = {1'b1, attr[0], nib};
                end
            end
        end
        w = pal_model[idx];
        return {expand(w[14:10]), expand(w[9:5]), expand(w[4:0])};
    endfunction

    task automatic check_frame();
        logic [23:0] exp;
        for (int y = 0; y < 32; y++) begin
            for (int x = 0; x < 64; x++) begin
                exp = expected_rgb(x, y);
                assert (frame[y * 64 + x] === exp)
                    else report_value($sformatf("rgb at %0d,%0d", x, y), 32'(exp),
                                      32'(frame[y * 64 + x]));
            end
        end
    endtask

    task automatic set_palette();
        for (int i = 0; i < 64; i++) begin
            pal_model[i] = {1'b0, 5'(i), 1'(i >> 5), 4'(i * 5), 5'(31 - (i & 31))};
            cpu_write(`PAL_BASE + 12'(2 * i), pal_model[i][15:8]);
            cpu_write(`PAL_BASE + 12'(2 * i + 1), pal_model[i][7:0]);
        end
    endtask

    task automatic set_map();
        for (int i = 0; i < 128; i++) begin
            map_model[i] = 8'(i * 7 + 3);
            cpu_write(`MAP_BASE + 12'(i), map_model[i]);
        end
    endtask

    task automatic set_scroll(input logic [7:0] value);
        scroll_model = value;
        cpu_write(`SCROLL_ADDR, value);
    endtask

    task automatic set_sprite(input int s, input logic [7:0] y, input logic [7:0] x,
                              input logic [7:0] code, input logic [7:0] attr);
        spr_model[4 * s]     = y;
        spr_model[4 * s + 1] = x;
        spr_model[4 * s + 2] = code;
        spr_model[4 * s + 3] = attr;
        for (int k = 0; k < 4; k++)
            cpu_write(`OBJ_BASE + 12'(4 * s + k), spr_model[4 * s + k]);
    endtask

    task automatic test_timing();
        int   run, lines, vis_lines, vs_pulses, hs_pulses, n;
        logic prev_lhbl, prev_lvbl, prev_vs, prev_hs;
        test_name = "timing";
        test_errors = 0;
        assert ({red, green, blue} == 24'd0)
            else report_value("rgb after reset", 32'd0, 32'({red, green, blue}));
        assert (!cpu_rvalid) else report_value("cpu_rvalid after reset", 32'd0, 32'd1);
        n = 0;
        next_pixel();
        while (lvbl && n < 4000) begin
            next_pixel();
            n++;
        end
        while (!lvbl && n < 8000) begin  // Stop on the first visible pixel
            next_pixel();
            n++;
        end
        prev_lhbl = 1'b0;
        prev_lvbl = 1'b0;
        prev_vs   = vs;
        prev_hs   = hs;
        run       = 0;
        lines     = 0;
        vis_lines = 0;
        vs_pulses = 0;
        hs_pulses = 0;
        for (int i = 0; i < `H_TOTAL * `V_TOTAL; i++) begin
            if (i > 0)
                next_pixel();
            if (lhbl)
                run++;
            if (prev_lhbl && !lhbl) begin
                assert (run == `H_ACTIVE)
                    else report_value("active pixels in a line", `H_ACTIVE, 32'(run));
                lines++;
                if (prev_lvbl)
                    vis_lines++;
                run = 0;
            end
            if (vs && !prev_vs) begin
                vs_pulses++;
                assert (i == `VS_LINE * `H_TOTAL)
                    else report_value("vs start position", `VS_LINE * `H_TOTAL, 32'(i));
            end
            if (hs && !prev_hs) begin
                hs_pulses++;
                assert ((i % `H_TOTAL) == `HS_START)
                    else report_value("hs start pixel", `HS_START, 32'(i % `H_TOTAL));
            end
            if (!hs && prev_hs) begin
                assert ((i % `H_TOTAL) == `HS_END)
                    else report_value("hs end pixel", `HS_END, 32'(i % `H_TOTAL));
            end
            prev_lhbl = lhbl;
            prev_lvbl = lvbl;
            prev_vs   = vs;
            prev_hs   = hs;
        end
        assert (lines == `V_TOTAL) else report_value("lines per frame", `V_TOTAL, 32'(lines));
        assert (vis_lines == `V_ACTIVE)
            else report_value("visible lines", `V_ACTIVE, 32'(vis_lines));
        assert (vs_pulses == 1) else report_value("vs pulses", 32'd1, 32'(vs_pulses));
        assert (hs_pulses == `V_TOTAL)
            else report_value("hs pulses", `V_TOTAL, 32'(hs_pulses));
        finish_test();
    endtask

    task automatic test_palette_rw();
        logic [6:0] addr [16];
        logic [7:0] data [16];
        logic [7:0] rd;
        test_name = "palette";
        test_errors = 0;
        for (int i = 0; i < 16; i++) begin
            addr[i] = {4'(i), 3'($random(seed))};  // Distinct byte addresses
            data[i] = 8'($random(seed));
            cpu_write(`PAL_BASE | 12'(addr[i]), data[i]);
        end
        for (int i = 0; i < 16; i++) begin
            cpu_read(`PAL_BASE | 12'(addr[i]), rd);
            assert (rd === data[i])
                else report_value($sformatf("byte at %0h", addr[i]), 32'(data[i]), 32'(rd));
        end
        finish_test();
    endtask

    task automatic test_tiles();
        test_name = "tiles";
        test_errors = 0;
        set_palette();
        set_map();
        set_scroll(8'd0);
        for (int s = 0; s < 4; s++)
            set_sprite(s, 8'd200, 8'd0, 8'd0, 8'd0);  // Off screen
        capture_frame();
        check_frame();
        finish_test();
    endtask

    task automatic test_scroll();
        logic [7:0] values [4];
        test_name = "scroll";
        test_errors = 0;
        values = '{8'd3, 8'd21, 8'd100, 8'd251};
        for (int i = 0; i < 4; i++) begin
            set_scroll(values[i]);
            capture_frame();
            check_frame();
        end
        finish_test();
    endtask

    task automatic test_sprites();
        test_name = "sprites";
        test_errors = 0;
        set_scroll(8'd5);
        set_sprite(0, 8'd4, 8'd10, 8'h21, 8'h00);
        set_sprite(1, 8'd6, 8'd14, 8'h13, 8'h81);  // Behind in bank 1 under sprite 0
        set_sprite(2, 8'd2, 8'd60, 8'h05, 8'h01);  // Clipped at the right edge
        set_sprite(3, 8'd20, 8'd30, 8'h2a, 8'h80);
        capture_frame();
        check_frame();
        finish_test();
    endtask

    initial begin
        seed         = 32'h396f75ca;
        errors       = 0;
        failed_tests = 0;
        test_errors  = 0;
        test_name    = "reset";
        cpu          = '0;
        reset        = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        test_timing();
        test_palette_rw();
        test_tiles();
        test_scroll();
        test_sprites();
        $display("Tests: 5, failed: %0d, errors: %0d", failed_tests, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
video_pkg.sv
bus_pkg.sv
video_timing.sv
tile_layer.sv
obj_layer.sv
gfx_rom_arbiter.sv
color_mixer.sv
video_top.sv
video_tb.sv

// File: Makefile
# Verilator build and run of the video subsystem testbench

.PHONY: all lint clean

all: obj_dir/Vvideo_tb
	./obj_dir/Vvideo_tb > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^Finished with no errors$$" sim.log

obj_dir/Vvideo_tb: filelist.f video_defines.svh *.sv
	verilator --binary --timing --assert -Wno-fatal --top-module video_tb -f filelist.f

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module video_top -f filelist.f

clean:
	rm -rf obj_dir sim.log
